/* Bender.yml */
package:
  name: apu_frame

sources:
  - common/apu_pkg.sv
  - src/apu_clk_enables.sv
  - apu_bus/apu_axil_slave.sv
  - frame_counter/frame_counter.sv
  - src/length_counter.sv
  - src/apu_frame_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/apu_frame_props.sv
      - test/apu_frame_tb.sv

/* apu_bus/apu_axil_slave.sv */
module apu_axil_slave (
  input  logic        clk,
  input  logic        rst_l,
  input  logic        cpu_clk_en,
  input  logic [15:0] s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [7:0]  s_wdata,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [15:0] s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [7:0]  s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready,
  input  logic        status_irq,
  input  logic        status_active,
  output logic [15:0] reg_addr,
  output logic [7:0]  reg_wdata,
  output logic        reg_we,
  output logic        reg_re
);

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  apu_pkg::bus_state_e state, state_next;
  logic        wr_take, rd_take, issue;
  logic        wr_mapped, rd_mapped;
  logic        is_read;
  logic [15:0] addr_q;
  logic [7:0]  wdata_q, rdata_q;
  logic [1:0]  resp_q;

  // Write needs aw and w together; a half-presented write still blocks reads
  assign wr_take = (state == apu_pkg::bus_idle) & s_awvalid & s_wvalid;
  assign rd_take = (state == apu_pkg::bus_idle) & s_arvalid & ~s_awvalid & ~s_wvalid;

  assign s_awready = wr_take;
  assign s_wready  = wr_take;
  assign s_arready = rd_take;

  assign wr_mapped = (addr_q == apu_pkg::addr_frame) | (addr_q == apu_pkg::addr_len_cfg) |
                     (addr_q == apu_pkg::addr_len_load);
  assign rd_mapped = (addr_q == apu_pkg::addr_status);

  assign issue     = (state == apu_pkg::bus_wait_en) & cpu_clk_en;
  assign reg_we    = issue & ~is_read & wr_mapped;
  assign reg_re    = issue & is_read & rd_mapped;
  assign reg_addr  = addr_q;
  assign reg_wdata = wdata_q;

  always_comb begin
    state_next = state;
    case (state)
      apu_pkg::bus_idle:
        if (wr_take | rd_take)
          state_next = apu_pkg::bus_wait_en;
      apu_pkg::bus_wait_en:
        if (cpu_clk_en)
          state_next = apu_pkg::bus_resp;
      apu_pkg::bus_resp:
        if (is_read ? s_rready : s_bready)
          state_next = apu_pkg::bus_idle;
      default:
        state_next = apu_pkg::bus_idle;
    endcase
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      state <= apu_pkg::bus_idle;
    else
      state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (wr_take) begin
      addr_q  <= s_awaddr;
      wdata_q <= s_wdata;
      is_read <= 1'b0;
    end else if (rd_take) begin
      addr_q  <= s_araddr;
      wdata_q <= '0;
      is_read <= 1'b1;
    end
    // Status sampled in the strobe cycle, before the clear lands
    if (issue) begin
      resp_q  <= (is_read ? rd_mapped : wr_mapped) ? resp_okay : resp_slverr;
      rdata_q <= (is_read & rd_mapped) ? {1'b0, status_irq, 5'b0, status_active} : 8'h00;
    end
  end

  assign s_bvalid = (state == apu_pkg::bus_resp) & ~is_read;
  assign s_rvalid = (state == apu_pkg::bus_resp) & is_read;
  assign s_bresp  = resp_q;
  assign s_rresp  = resp_q;
  assign s_rdata  = rdata_q;

endmodule

/* common/apu_pkg.sv */
package apu_pkg;

  // Register map, console addresses
  localparam logic [15:0] addr_len_cfg  = 16'h4000;
  localparam logic [15:0] addr_len_load = 16'h4003;
  localparam logic [15:0] addr_status   = 16'h4015;
  localparam logic [15:0] addr_frame    = 16'h4017;

  // Sequencer steps in APU cycles
  localparam logic [15:0] step1 = 16'd3728;
  localparam logic [15:0] step2 = 16'd7456;
  localparam logic [15:0] step3 = 16'd11185;
  localparam logic [15:0] step4 = 16'd14914;
  localparam logic [15:0] step5 = 16'd18640;

  typedef enum logic {
    mode_4step,
    mode_5step
  } frame_mode_e;

  typedef enum logic [1:0] {
    bus_idle,
    bus_wait_en,
    bus_resp
  } bus_state_e;

  // Length load values, indexed by data bits 7:3
  localparam logic [7:0] length_table [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,
    8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,
    8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,
    8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,
    8'd16,  8'd28,  8'd32,  8'd30
  };

endpackage

/* frame_counter/frame_counter.sv */
module frame_counter (
  input  logic        clk,
  input  logic        rst_l,
  input  logic        cpu_clk_en,
  input  logic        apu_clk_en,
  input  logic [15:0] reg_addr,
  input  logic [7:0]  reg_wdata,
  input  logic        reg_we,
  input  logic        reg_re,
  output logic        irq,
  output logic        quarter_tick,
  output logic        half_tick
);

  apu_pkg::frame_mode_e mode, mode_next;
  logic        inhibit, inhibit_next;
  logic [15:0] cycles, cycles_next;
  logic        load;
  logic        clear_irq;
  logic        set_irq;

  assign load      = reg_we & (reg_addr == apu_pkg::addr_frame);
  assign clear_irq = (reg_re & (reg_addr == apu_pkg::addr_status)) | (load & reg_wdata[6]);
  assign set_irq   = apu_clk_en & (mode == apu_pkg::mode_4step) &
                     (cycles == apu_pkg::step4) & ~inhibit;

  always_comb begin
    mode_next    = mode;
    inhibit_next = inhibit;
    if (load) begin
      mode_next    = apu_pkg::frame_mode_e'(reg_wdata[7]);
      inhibit_next = reg_wdata[6];
    end
  end

  always_comb begin
    cycles_next  = cycles;
    quarter_tick = 1'b0;
    half_tick    = 1'b0;

    if (apu_clk_en) begin
      cycles_next = cycles + 16'd1;
      if (cycles == apu_pkg::step1) begin
        quarter_tick = 1'b1;
      end else if (cycles == apu_pkg::step2) begin
        quarter_tick = 1'b1;
        half_tick    = 1'b1;
      end else if (cycles == apu_pkg::step3) begin
        quarter_tick = 1'b1;
      end else if ((mode == apu_pkg::mode_4step) && (cycles == apu_pkg::step4)) begin
        quarter_tick = 1'b1;
        half_tick    = 1'b1;
        cycles_next  = '0;
      end else if (cycles == apu_pkg::step5) begin
        // Reached in 4-step mode only right after a frame write, no ticks then
        quarter_tick = (mode == apu_pkg::mode_5step);
        half_tick    = (mode == apu_pkg::mode_5step);
        cycles_next  = '0;
      end
    end

    if (load)
      cycles_next = apu_pkg::step5;
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      cycles  <= '0;
      mode    <= apu_pkg::mode_4step;
      inhibit <= 1'b0;
    end else if (cpu_clk_en) begin
      cycles  <= cycles_next;
      mode    <= mode_next;
      inhibit <= inhibit_next;
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      irq <= 1'b0;
    else if (set_irq)
      irq <= 1'b1;
    else if (cpu_clk_en & clear_irq)
      irq <= 1'b0;
  end

endmodule

/* sources.f */
common/apu_pkg.sv
src/apu_clk_enables.sv
apu_bus/apu_axil_slave.sv
frame_counter/frame_counter.sv
src/length_counter.sv
src/apu_frame_top.sv
test/tb_clock.sv
test/apu_frame_props.sv
test/apu_frame_tb.sv

/* src/apu_clk_enables.sv */
module apu_clk_enables #(
  parameter int cpu_div = 12
) (
  input  logic clk,
  input  logic rst_l,
  output logic cpu_clk_en,
  output logic apu_clk_en
);

  localparam int cnt_w = (cpu_div > 1) ? $clog2(cpu_div) : 1;

  logic [cnt_w-1:0] div_cnt;
  logic             apu_phase;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      div_cnt   <= '0;
      apu_phase <= 1'b0;
    end else begin
      if (div_cnt == '0)
        div_cnt <= cnt_w'(cpu_div - 1);
      else
        div_cnt <= div_cnt - 1'b1;
      if (cpu_clk_en)
        apu_phase <= ~apu_phase;
    end
  end

  assign cpu_clk_en = (div_cnt == '0);
  // APU runs at half the CPU rate
  assign apu_clk_en = cpu_clk_en & apu_phase;

endmodule

/* src/apu_frame_top.sv */
module apu_frame_top #(
  parameter int cpu_div = 12
) (
  input  logic        clk,
  input  logic        rst_l,
  input  logic [15:0] s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [7:0]  s_wdata,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [15:0] s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [7:0]  s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready,
  output logic        irq,
  output logic        quarter_tick,
  output logic        half_tick,
  output logic        length_active
);

  logic        cpu_clk_en;
  logic        apu_clk_en;
  logic [15:0] reg_addr;
  logic [7:0]  reg_wdata;
  logic        reg_we;
  logic        reg_re;

  apu_clk_enables #(.cpu_div(cpu_div)) clk_en0 (
    .clk, .rst_l, .cpu_clk_en, .apu_clk_en
  );

  apu_axil_slave bus0 (
    .clk, .rst_l, .cpu_clk_en,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .status_irq(irq), .status_active(length_active),
    .reg_addr, .reg_wdata, .reg_we, .reg_re
  );

  frame_counter frame0 (
    .clk, .rst_l, .cpu_clk_en, .apu_clk_en,
    .reg_addr, .reg_wdata, .reg_we, .reg_re,
    .irq, .quarter_tick, .half_tick
  );

  length_counter len0 (
    .clk, .rst_l, .cpu_clk_en, .half_tick,
    .reg_addr, .reg_wdata, .reg_we,
    .active(length_active)
  );

endmodule

/* src/length_counter.sv */
module length_counter (
  input  logic        clk,
  input  logic        rst_l,
  input  logic        cpu_clk_en,
  input  logic        half_tick,
  input  logic [15:0] reg_addr,
  input  logic [7:0]  reg_wdata,
  input  logic        reg_we,
  output logic        active
);

  logic [7:0] length;
  logic       halt;
  logic       cfg_wr;
  logic       load_wr;
  logic       dec;

  assign cfg_wr  = reg_we & (reg_addr == apu_pkg::addr_len_cfg);
  assign load_wr = reg_we & (reg_addr == apu_pkg::addr_len_load);
  assign dec     = half_tick & ~halt & (length != 8'd0);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      halt <= 1'b0;
    else if (cpu_clk_en & cfg_wr)
      halt <= reg_wdata[5];
  end

  // Load beats a decrement in the same cycle
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l)
      length <= 8'd0;
    else if (cpu_clk_en) begin
      if (load_wr)
        length <= apu_pkg::length_table[reg_wdata[7:3]];
      else if (dec)
        length <= length - 8'd1;
    end
  end

  assign active = (length != 8'd0);

endmodule

/* test/apu_frame_props.sv */
module apu_frame_props (
  input logic        clk,
  input logic        rst_l,
  input logic        cpu_clk_en,
  input logic        apu_clk_en,
  input logic [15:0] reg_addr,
  input logic [7:0]  reg_wdata,
  input logic        reg_we,
  input logic        reg_re,
  input logic        irq,
  input logic        quarter_tick,
  input logic        half_tick,
  input logic        length_active,
  input logic        s_awready,
  input logic        s_wready,
  input logic        s_arready,
  input logic        s_bvalid,
  input logic        s_bready
);

  int         fails = 0;
  logic       seen_tick, restart, mode5, inhibit;
  logic [2:0] q_cnt, h_cnt;
  logic       frame_wr, frame_end;

  assign frame_wr  = cpu_clk_en & reg_we & (reg_addr == apu_pkg::addr_frame);
  // Second half tick of a frame closes it
  assign frame_end = half_tick & (h_cnt == 3'd1) & ~restart & ~frame_wr;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      seen_tick <= 1'b0;
      restart   <= 1'b0;
      mode5     <= 1'b0;
      inhibit   <= 1'b0;
      q_cnt     <= '0;
      h_cnt     <= '0;
    end else begin
      if (quarter_tick)
        seen_tick <= 1'b1;
      if (frame_wr) begin
        restart <= 1'b1;
        mode5   <= reg_wdata[7];
        inhibit <= reg_wdata[6];
        q_cnt   <= '0;
        h_cnt   <= '0;
      end else if ((restart & apu_clk_en) | frame_end) begin
        restart <= 1'b0;
        q_cnt   <= '0;
        h_cnt   <= '0;
      end else begin
        q_cnt <= q_cnt + 3'(quarter_tick);
        h_cnt <= h_cnt + 3'(half_tick);
      end
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_l)
    !seen_tick |-> !irq && !half_tick && !length_active)
    else begin $error("outputs active before the first quarter tick"); fails++; end

  a_frame_ticks: assert property (@(posedge clk) disable iff (!rst_l)
    frame_end |-> quarter_tick && (q_cnt == 3'd3))
    else begin $error("frame did not hold 4 quarter and 2 half ticks"); fails++; end

  // Tick right after a frame write depends on the new mode
  a_restart_ticks: assert property (@(posedge clk) disable iff (!rst_l)
    (restart && apu_clk_en && !frame_wr) |-> (quarter_tick == mode5) && (half_tick == mode5))
    else begin $error("wrong ticks after frame write"); fails++; end

  a_irq_source: assert property (@(posedge clk) disable iff (!rst_l)
    $rose(irq) |-> $past(quarter_tick && half_tick && !mode5 && !inhibit))
    else begin $error("irq rose outside a 4-step frame end or while inhibited"); fails++; end

  a_irq_at_frame_end: assert property (@(posedge clk) disable iff (!rst_l)
    (frame_end && !mode5 && !inhibit) |=> irq)
    else begin $error("irq missing after 4-step frame end"); fails++; end

  a_irq_clear: assert property (@(posedge clk) disable iff (!rst_l)
    ((reg_re && cpu_clk_en) || (frame_wr && reg_wdata[6])) && !(quarter_tick && half_tick)
    |=> !irq)
    else begin $error("irq not cleared by status read or frame write"); fails++; end

  a_resp_stall: assert property (@(posedge clk) disable iff (!rst_l)
    (s_bvalid && !s_bready) |=> s_bvalid && !s_awready && !s_wready && !s_arready)
    else begin $error("write response dropped or bus accepted during stall"); fails++; end

endmodule

/* test/apu_frame_tb.sv */
module apu_frame_tb;

  localparam int bus_limit  = 50;
  // Clk cycles, wider than any gap between two ticks
  localparam int tick_limit = 32000;

  // Console length table
  localparam logic [7:0] len_ref [32] = '{
    8'd10,  8'd254, 8'd20, 8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
    8'd160, 8'd8,   8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
    8'd12,  8'd16,  8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
    8'd192, 8'd24,  8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
  };

  logic        clk, rst_l;
  logic [15:0] s_awaddr, s_araddr;
  logic [7:0]  s_wdata, s_rdata;
  logic        s_awvalid, s_awready, s_wvalid, s_wready;
  logic [1:0]  s_bresp, s_rresp;
  logic        s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
  logic        irq, quarter_tick, half_tick, length_active;
  int          errors;
  bit          aborted;
  logic [31:0] rng;
  logic [4:0]  idx;

  tb_clock #(.period(40)) clk0 (.clk);

  apu_frame_top #(.cpu_div(1)) dut0 (.*);

  bind apu_frame_top apu_frame_props props0 (
    .clk, .rst_l, .cpu_clk_en, .apu_clk_en, .reg_addr, .reg_wdata, .reg_we, .reg_re,
    .irq, .quarter_tick, .half_tick, .length_active,
    .s_awready, .s_wready, .s_arready, .s_bvalid, .s_bready
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    errors++;
    aborted = 1'b1;
    $display("Timeout: %s", why);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (!aborted && got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [7:0] data,
                           input logic [1:0] exp_resp, input int hold);
    int n;
    if (aborted) return;
    @(posedge clk);
    #5;
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = (hold == 0);
    n = 0;
    #1;
    while (!(s_awready && s_wready) && !aborted) begin
      if (n >= bus_limit) abort_run("write address and data were never accepted");
      else begin
        @(posedge clk);
        #6;
        n++;
      end
    end
    @(posedge clk);
    #5;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    n = 0;
    #1;
    while (!s_bvalid && !aborted) begin
      if (n >= bus_limit) abort_run("write response never arrived");
      else begin
        @(posedge clk);
        #6;
        n++;
      end
    end
    if (aborted) return;
    check_val("s_bresp", s_bresp, exp_resp);
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      #5;
      check_val("s_bvalid", s_bvalid, 1);
      s_bready = 1'b1;
    end
    @(posedge clk);
    #5;
  endtask

  task automatic axi_read(input logic [15:0] addr, input logic [1:0] exp_resp,
                          input logic [7:0] exp_data);
    int n;
    if (aborted) return;
    @(posedge clk);
    #5;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    n = 0;
    #1;
    while (!s_arready && !aborted) begin
      if (n >= bus_limit) abort_run("read address was never accepted");
      else begin
        @(posedge clk);
        #6;
        n++;
      end
    end
    @(posedge clk);
    #5;
    s_arvalid = 1'b0;
    n = 0;
    #1;
    while (!s_rvalid && !aborted) begin
      if (n >= bus_limit) abort_run("read data never arrived");
      else begin
        @(posedge clk);
        #6;
        n++;
      end
    end
    if (aborted) return;
    check_val("s_rresp", s_rresp, exp_resp);
    check_val("s_rdata", s_rdata, exp_data);
    @(posedge clk);
    #5;
  endtask

  task automatic wait_irq;
    int n;
    n = 0;
    while (!irq && !aborted) begin
      if (n >= 2 * tick_limit) abort_run("frame interrupt never rose");
      else begin
        @(posedge clk);
        #6;
        n++;
      end
    end
  endtask

  task automatic wait_ticks(input logic half, input int count);
    int n, seen;
    n = 0;
    seen = 0;
    while (seen < count && !aborted) begin
      if (n >= count * tick_limit) abort_run("frame ticks stopped");
      else begin
        @(posedge clk);
        #6;
        n++;
        if (half ? half_tick : quarter_tick)
          seen++;
      end
    end
  endtask

  // Half ticks seen at the ports until the channel goes quiet
  task automatic count_length(input int expected);
    int n, seen;
    n = 0;
    seen = 0;
    while (length_active && !aborted) begin
      if (n >= 20 * tick_limit) abort_run("length counter never ran out");
      else begin
        if (half_tick)
          seen++;
        @(posedge clk);
        #6;
        n++;
      end
    end
    check_val("half ticks until length_active low", seen, expected);
  endtask

  initial begin
    errors    = 0;
    aborted   = 1'b0;
    rng       = 32'hb29b;
    rst_l     = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b1;
    repeat (16) @(posedge clk);
    #5;
    rst_l = 1'b1;

    wait_ticks(1'b0, 1);

    // Status read returns and clears the interrupt, channel still idle
    wait_irq();
    axi_read(apu_pkg::addr_status, 2'b00, 8'h40);
    check_val("irq", irq, 0);

    // Unmapped accesses, the read waits behind the held write response
    wait_irq();
    fork
      axi_write(16'h4008, 8'hff, 2'b10, 3);
      axi_read(apu_pkg::addr_frame, 2'b10, 8'h00);
    join
    check_val("irq", irq, 1);
    check_val("length_active", length_active, 0);

    // Inhibit set clears irq and keeps it low
    rng = xorshift(rng);
    axi_write(apu_pkg::addr_frame, {2'b01, rng[5:0]}, 2'b00, 0);
    check_val("irq", irq, 0);
    wait_ticks(1'b1, 4);
    check_val("irq", irq, 0);

    // 5-step mode never raises irq
    rng = xorshift(rng);
    axi_write(apu_pkg::addr_frame, {1'b1, rng[6:0]}, 2'b00, 0);
    wait_ticks(1'b1, 4);
    check_val("irq", irq, 0);

    // Length runs out after its table value in half ticks
    rng = xorshift(rng);
    axi_write(apu_pkg::addr_len_cfg, {rng[7:6], 1'b0, rng[4:0]}, 2'b00, 0);
    do begin
      rng = xorshift(rng);
      idx = rng[4:0];
    end while (len_ref[idx] > 8'd16);
    wait_ticks(1'b1, 1);
    axi_write(apu_pkg::addr_len_load, {idx, rng[10:8]}, 2'b00, 0);
    check_val("length_active", length_active, 1);
    count_length(len_ref[idx]);

    // Halt keeps the channel active
    rng = xorshift(rng);
    axi_write(apu_pkg::addr_len_cfg, {rng[7:6], 1'b1, rng[4:0]}, 2'b00, 0);
    rng = xorshift(rng);
    axi_write(apu_pkg::addr_len_load, rng[7:0], 2'b00, 0);
    wait_ticks(1'b1, 4);
    check_val("length_active", length_active, 1);

    // Status shows the active channel with no interrupt in 5-step mode
    axi_read(apu_pkg::addr_status, 2'b00, 8'h01);

    $display("Errors: %0d in testbench checks, %0d in assertions", errors, dut0.props0.fails);
    if (errors == 0 && dut0.props0.fails == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* test/tb_clock.sv */
module tb_clock #(
  parameter int period = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period / 2) clk = ~clk;

endmodule
